/* design/snes_load_pkg.sv */
package snes_load_pkg;

  // data paths
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;

  // loader byte address, one bit wider than the sdram space
  typedef logic [24:0] ioctl_addr_t;
  typedef logic [23:0] rom_addr_t;
  typedef logic [23:0] mask_t;

  // header size code, size = 1 KiB << code
  typedef logic [3:0]  size_code_t;

  // audio ram, 64 KiB seen as 32K words
  typedef logic [15:0] aram_addr_t;
  typedef logic [14:0] aram_word_addr_t;

  // clear sweep runs over 128K steps
  typedef logic [16:0] fill_addr_t;
  typedef logic [1:0]  fill_mode_t;

  typedef enum logic {
    CLEAR_IDLE,
    CLEAR_RUN
  } clear_state_t;

  localparam mask_t MASK_UNIT = 24'd1024;
  // settle countdown start after a download ends
  localparam logic [2:0] SETTLE_CYCLES = 3'd6;
  // spc image header sits before audio ram data
  localparam aram_addr_t SPC_LOAD_OFFSET = 16'h0100;

  // fill patterns
  localparam byte_t FILL_A_HI = 8'h66;
  localparam byte_t FILL_A_LO = 8'h99;
  localparam byte_t FILL_B_HI = 8'hFF;
  localparam byte_t FILL_B_LO = 8'h00;
  localparam byte_t FILL_C    = 8'h55;
  localparam byte_t FILL_D    = 8'hFF;

  // divider phase where core reset may change
  localparam logic [1:0] RELEASE_PHASE = 2'd2;

endpackage

/* design/load_sequencer.sv */
module load_sequencer (
  input  logic                    clk_sys,
  input  logic                    reset,
  input  logic                    cart_download,
  input  logic                    spc_download,
  input  logic                    ioctl_wr,
  input  snes_load_pkg::size_code_t rom_size,
  input  snes_load_pkg::size_code_t ram_size,
  output logic                    settling,
  output snes_load_pkg::mask_t    rom_mask,
  output snes_load_pkg::mask_t    ram_mask,
  output snes_load_pkg::size_code_t sram_size,
  output logic                    spc_mode
);
  import snes_load_pkg::*;

  // any download active last cycle
  logic       was_loading;
  logic [2:0] settle_cnt;
  logic       load_end;

  // falling edge of the combined download level
  assign load_end = was_loading && !cart_download && !spc_download;
  assign settling = (settle_cnt != 3'd0);

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      was_loading <= 1'b0;
      settle_cnt  <= 3'd0;
      rom_mask    <= '0;
      ram_mask    <= '0;
      sram_size   <= '0;
      spc_mode    <= 1'b0;
    end else begin
      was_loading <= cart_download || spc_download;

      // restart countdown, else run it down to zero
      if (load_end) begin
        settle_cnt <= SETTLE_CYCLES;
      end else if (settling) begin
        settle_cnt <= settle_cnt - 3'd1;
      end

      // last step of countdown, header codes are stable now
      if (settle_cnt == 3'd1) begin
        rom_mask  <= (MASK_UNIT << rom_size) - 24'd1;
        // no save ram means an empty mask
        ram_mask  <= (ram_size != '0) ? (MASK_UNIT << ram_size) - 24'd1 : '0;
        sram_size <= ram_size;
      end

      // last written image decides the mode
      if (ioctl_wr) begin
        spc_mode <= spc_download;
      end
    end
  end

endmodule

/* design/ram_clear_seq.sv */
module ram_clear_seq (
  input  logic                         clk_sys,
  input  logic                         reset,
  input  logic                         cart_download,
  input  snes_load_pkg::fill_mode_t    fill_mode,
  output logic                         clearing,
  output snes_load_pkg::aram_word_addr_t fill_word_addr,
  output snes_load_pkg::byte_t         fill_byte
);
  import snes_load_pkg::*;

  clear_state_t state;
  fill_addr_t   fill_addr;
  // free running pace counter, one step per four cycles
  logic [1:0]   phase;
  logic         cart_q;

  assign clearing       = (state == CLEAR_RUN);
  assign fill_word_addr = fill_addr[15:1];

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      state     <= CLEAR_IDLE;
      fill_addr <= '0;
      phase     <= 2'd0;
      cart_q    <= 1'b0;
    end else begin
      cart_q <= cart_download;
      phase  <= phase + 2'd1;
      case (state)
        CLEAR_IDLE: begin
          fill_addr <= '0;
          // start on first cycle of a cartridge download
          if (cart_download && !cart_q) begin
            state <= CLEAR_RUN;
          end
        end
        CLEAR_RUN: begin
          if (phase == 2'd0) begin
            fill_addr <= fill_addr + 17'd1;
          end
          // sweep done once the last address was written
          if (&fill_addr) begin
            state <= CLEAR_IDLE;
          end
        end
        default: state <= CLEAR_IDLE;
      endcase
    end
  end

  // pattern for the current sweep address
  always_comb begin
    case (fill_mode)
      2'd0: fill_byte = (fill_addr[8] ^ fill_addr[2]) ? FILL_A_HI : FILL_A_LO;
      2'd1: fill_byte = (fill_addr[9] ^ fill_addr[0]) ? FILL_B_HI : FILL_B_LO;
      2'd2: fill_byte = FILL_C;
      default: fill_byte = FILL_D;
    endcase
  end

endmodule

/* design/sdram_port_ctrl.sv */
module sdram_port_ctrl (
  input  logic                      clk_sys,
  input  logic                      reset,
  input  logic                      core_hold,
  input  logic                      cart_download,
  input  logic                      ioctl_wr,
  input  snes_load_pkg::ioctl_addr_t ioctl_addr,
  input  snes_load_pkg::word_t      ioctl_dout,
  input  snes_load_pkg::rom_addr_t  rom_addr,
  input  snes_load_pkg::word_t      rom_d,
  input  logic                      rom_oe,
  input  logic                      rom_we,
  input  logic                      rom_word,
  output logic                      core_reset_n,
  output snes_load_pkg::rom_addr_t  sdram_addr,
  output snes_load_pkg::word_t      sdram_din,
  output logic                      sdram_rd,
  output logic                      sdram_wr,
  output logic                      sdram_word
);
  import snes_load_pkg::*;

  // four phase divider
  logic [1:0] div;
  // refresh strobe, one cycle in four
  logic       rfsh;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      div          <= 2'd0;
      rfsh         <= 1'b0;
      core_reset_n <= 1'b0;
    end else begin
      div  <= div + 2'd1;
      rfsh <= (div == 2'd0);
      // reset edges only on one fixed phase
      if (div == RELEASE_PHASE) begin
        core_reset_n <= !core_hold;
      end
    end
  end

  // request steering, loader owns the port during a cart download
  always_comb begin
    if (cart_download) begin
      // rom image goes in as whole words
      sdram_addr = ioctl_addr[23:0];
      sdram_din  = ioctl_dout;
      sdram_wr   = ioctl_wr;
      sdram_rd   = 1'b0;
      sdram_word = 1'b1;
    end else begin
      sdram_addr = rom_addr;
      sdram_din  = rom_d;
      sdram_wr   = rom_we;
      sdram_word = rom_word;
      // held core issues no reads, the refresh strobe keeps the controller busy
      if (core_reset_n) begin
        sdram_rd = rom_oe;
      end else begin
        sdram_rd = rfsh;
      end
    end
  end

endmodule

/* design/aram_store.sv */
module aram_store (
  input  logic                           clk_sys,
  input  logic                           clearing,
  input  logic                           spc_download,
  input  logic                           ioctl_wr,
  input  snes_load_pkg::ioctl_addr_t     ioctl_addr,
  input  snes_load_pkg::word_t           ioctl_dout,
  input  snes_load_pkg::aram_word_addr_t fill_word_addr,
  input  snes_load_pkg::byte_t           fill_byte,
  input  snes_load_pkg::aram_addr_t      aram_addr,
  input  snes_load_pkg::byte_t           aram_d,
  input  logic                           aram_we,
  output snes_load_pkg::byte_t           aram_q
);
  import snes_load_pkg::*;

  // 32K x 16 audio ram
  word_t           mem [0:32767];

  aram_addr_t      spc_addr;
  logic            wr_en;
  aram_word_addr_t wr_addr;
  word_t           wr_data;
  logic [1:0]      wr_be;
  word_t           rd_word;

  // spc image data starts past the header
  assign spc_addr = ioctl_addr[15:0] - SPC_LOAD_OFFSET;

  // one shared write port, spc first, then clear, then core
  always_comb begin
    if (spc_download) begin
      wr_en   = ioctl_wr;
      wr_addr = spc_addr[15:1];
      wr_data = ioctl_dout;
      wr_be   = 2'b11;
    end else if (clearing) begin
      wr_en   = 1'b1;
      wr_addr = fill_word_addr;
      wr_data = {fill_byte, fill_byte};
      wr_be   = 2'b11;
    end else begin
      wr_en   = aram_we;
      wr_addr = aram_addr[15:1];
      wr_data = {aram_d, aram_d};
      // odd byte lives in the high half
      wr_be   = aram_addr[0] ? 2'b10 : 2'b01;
    end
  end

  assign rd_word = mem[aram_addr[15:1]];

  always_ff @(posedge clk_sys) begin
    if (wr_en && wr_be[0]) begin
      mem[wr_addr][7:0] <= wr_data[7:0];
    end
    if (wr_en && wr_be[1]) begin
      mem[wr_addr][15:8] <= wr_data[15:8];
    end
    // registered byte read for the core
    aram_q <= aram_addr[0] ? rd_word[15:8] : rd_word[7:0];
  end

endmodule

/* design/snes_load_top.sv */
module snes_load_top (
  input  logic                      clk_sys,
  input  logic                      reset,
  input  logic                      core_reset,
  input  logic                      cart_download,
  input  logic                      spc_download,
  input  logic                      ioctl_wr,
  input  snes_load_pkg::ioctl_addr_t ioctl_addr,
  input  snes_load_pkg::word_t      ioctl_dout,
  input  snes_load_pkg::size_code_t rom_size,
  input  snes_load_pkg::size_code_t ram_size,
  input  snes_load_pkg::fill_mode_t fill_mode,
  input  snes_load_pkg::rom_addr_t  rom_addr,
  input  snes_load_pkg::word_t      rom_d,
  input  logic                      rom_oe,
  input  logic                      rom_we,
  input  logic                      rom_word,
  input  snes_load_pkg::aram_addr_t aram_addr,
  input  snes_load_pkg::byte_t      aram_d,
  input  logic                      aram_we,
  output snes_load_pkg::mask_t      rom_mask,
  output snes_load_pkg::mask_t      ram_mask,
  output snes_load_pkg::size_code_t sram_size,
  output logic                      spc_mode,
  output logic                      core_reset_n,
  output snes_load_pkg::rom_addr_t  sdram_addr,
  output snes_load_pkg::word_t      sdram_din,
  output logic                      sdram_rd,
  output logic                      sdram_wr,
  output logic                      sdram_word,
  output snes_load_pkg::byte_t      aram_q
);
  import snes_load_pkg::*;

  logic            settling;
  logic            clearing;
  logic            core_hold;
  aram_word_addr_t fill_word_addr;
  byte_t           fill_byte;

  // core stays in reset through any load activity
  assign core_hold = core_reset || cart_download || spc_download || clearing || settling;

  load_sequencer u_load_sequencer (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .cart_download (cart_download),
    .spc_download  (spc_download),
    .ioctl_wr      (ioctl_wr),
    .rom_size      (rom_size),
    .ram_size      (ram_size),
    .settling      (settling),
    .rom_mask      (rom_mask),
    .ram_mask      (ram_mask),
    .sram_size     (sram_size),
    .spc_mode      (spc_mode)
  );

  ram_clear_seq u_ram_clear_seq (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .cart_download  (cart_download),
    .fill_mode      (fill_mode),
    .clearing       (clearing),
    .fill_word_addr (fill_word_addr),
    .fill_byte      (fill_byte)
  );

  sdram_port_ctrl u_sdram_port_ctrl (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .core_hold     (core_hold),
    .cart_download (cart_download),
    .ioctl_wr      (ioctl_wr),
    .ioctl_addr    (ioctl_addr),
    .ioctl_dout    (ioctl_dout),
    .rom_addr      (rom_addr),
    .rom_d         (rom_d),
    .rom_oe        (rom_oe),
    .rom_we        (rom_we),
    .rom_word      (rom_word),
    .core_reset_n  (core_reset_n),
    .sdram_addr    (sdram_addr),
    .sdram_din     (sdram_din),
    .sdram_rd      (sdram_rd),
    .sdram_wr      (sdram_wr),
    .sdram_word    (sdram_word)
  );

  // audio ram, loader and clear share the word port
  aram_store u_aram_store (
    .clk_sys        (clk_sys),
    .clearing       (clearing),
    .spc_download   (spc_download),
    .ioctl_wr       (ioctl_wr),
    .ioctl_addr     (ioctl_addr),
    .ioctl_dout     (ioctl_dout),
    .fill_word_addr (fill_word_addr),
    .fill_byte      (fill_byte),
    .aram_addr      (aram_addr),
    .aram_d         (aram_d),
    .aram_we        (aram_we),
    .aram_q         (aram_q)
  );

endmodule

/* sim/load_checker.sv */
module load_checker (
  input logic                       clk_sys,
  input logic                       reset,
  input logic                       cart_download,
  input logic                       ioctl_wr,
  input snes_load_pkg::ioctl_addr_t ioctl_addr,
  input snes_load_pkg::word_t       ioctl_dout,
  input snes_load_pkg::rom_addr_t   rom_addr,
  input snes_load_pkg::word_t       rom_d,
  input logic                       rom_oe,
  input logic                       rom_we,
  input logic                       rom_word,
  input logic                       core_reset_n,
  input snes_load_pkg::rom_addr_t   sdram_addr,
  input snes_load_pkg::word_t       sdram_din,
  input logic                       sdram_rd,
  input logic                       sdram_wr,
  input logic                       sdram_word,
  input snes_load_pkg::mask_t       rom_mask,
  input snes_load_pkg::mask_t       ram_mask,
  input snes_load_pkg::size_code_t  sram_size,
  input logic                       spc_mode,
  input snes_load_pkg::byte_t       aram_q
);
  import snes_load_pkg::*;

  // errors seen by the per-cycle watcher and by the called checks
  int         watch_errors = 0;
  int         call_errors = 0;
  // cycles in the current held window, last four sdram_rd samples
  int         held_run = 0;
  logic [3:0] rd_hist = '0;

  function automatic int error_total();
    return watch_errors + call_errors;
  endfunction

  task automatic report_fail(input string msg);
    $display("Fail at time %0t: %s", $time, msg);
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    call_errors++;
  endtask

  task automatic compare(input string what, input logic [23:0] got, input logic [23:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("%s is %h, expected %h", what, got, exp));
      call_errors++;
    end
  endtask

  task automatic check_reset_state();
    compare("core_reset_n", 24'(core_reset_n), 24'd0);
    compare("spc_mode", 24'(spc_mode), 24'd0);
    compare("rom_mask", rom_mask, 24'd0);
    compare("ram_mask", ram_mask, 24'd0);
    compare("sram_size", 24'(sram_size), 24'd0);
  endtask

  task automatic check_masks(input mask_t exp_rom, input mask_t exp_ram,
                             input size_code_t exp_sram, input logic exp_spc);
    compare("rom_mask", rom_mask, exp_rom);
    compare("ram_mask", ram_mask, exp_ram);
    compare("sram_size", 24'(sram_size), 24'(exp_sram));
    compare("spc_mode", 24'(spc_mode), 24'(exp_spc));
  endtask

  task automatic expect_byte(input aram_addr_t a, input byte_t exp, input string what);
    compare($sformatf("%s read of aram byte %h", what, a), 24'(aram_q), 24'(exp));
  endtask

  // port behavior checked on every rising edge
  always @(posedge clk_sys) begin
    if (!reset) begin
      held_run = 0;
    end else if (cart_download) begin
      held_run = 0;
      // loader owns the sdram port
      if (sdram_wr !== ioctl_wr || sdram_addr !== ioctl_addr[23:0] ||
          sdram_din !== ioctl_dout || sdram_rd !== 1'b0 || sdram_word !== 1'b1) begin
        report_fail($sformatf("loader steering wrong at ioctl_addr %h", ioctl_addr));
        watch_errors++;
      end
    end else begin
      // core owns the rest of the port
      if (sdram_addr !== rom_addr || sdram_din !== rom_d ||
          sdram_wr !== rom_we || sdram_word !== rom_word) begin
        report_fail($sformatf("core steering wrong at rom_addr %h", rom_addr));
        watch_errors++;
      end
      if (!core_reset_n) begin
        // held core, exactly one refresh read in any four cycles
        rd_hist = {rd_hist[2:0], sdram_rd};
        if (held_run < 4) begin
          held_run++;
        end
        if (held_run == 4 && $countones(rd_hist) != 1) begin
          report_fail($sformatf("refresh pattern %b while core held", rd_hist));
          watch_errors++;
        end
      end else begin
        held_run = 0;
        if (sdram_rd !== rom_oe) begin
          report_fail("sdram_rd does not follow rom_oe with the core running");
          watch_errors++;
        end
      end
    end
  end

endmodule

/* sim/tb_snes_load.sv */
module tb_snes_load;
  import snes_load_pkg::*;

  // one table row per test
  typedef struct packed {
    size_code_t rom_size;
    size_code_t ram_size;
    fill_mode_t fill_mode;
    mask_t      rom_mask;
    mask_t      ram_mask;
    size_code_t sram_size;
    int         spc_words;
  } row_t;

  localparam int NUM_ROWS = 4;
  // full clear sweep is 128K steps of four cycles
  localparam int CLEAR_TIMEOUT = 600000;
  localparam int SPC_TIMEOUT = 64;

  logic        clk_sys = 1'b0;
  logic        reset, core_reset, cart_download, spc_download, ioctl_wr;
  ioctl_addr_t ioctl_addr;
  word_t       ioctl_dout, rom_d, sdram_din;
  size_code_t  rom_size, ram_size, sram_size;
  fill_mode_t  fill_mode;
  rom_addr_t   rom_addr, sdram_addr;
  logic        rom_oe, rom_we, rom_word, aram_we;
  aram_addr_t  aram_addr;
  byte_t       aram_d, aram_q;
  mask_t       rom_mask, ram_mask;
  logic        spc_mode, core_reset_n, sdram_rd, sdram_wr, sdram_word;

  row_t        rows [NUM_ROWS];
  logic [31:0] lcg_state = 32'h299e6c15;
  logic [14:0] spc_wa [16];
  word_t       spc_data [16];
  int          failed_tests = 0;

  snes_load_top dut0 (.*);
  load_checker chk0 (.*);

  always #10 clk_sys = ~clk_sys;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // fill byte for an audio ram byte address
  function automatic byte_t fill_pattern(input fill_mode_t mode, input aram_addr_t a);
    case (mode)
      2'd0: return (a[8] ^ a[2]) ? FILL_A_HI : FILL_A_LO;
      2'd1: return (a[9] ^ a[0]) ? FILL_B_HI : FILL_B_LO;
      2'd2: return FILL_C;
      default: return FILL_D;
    endcase
  endfunction

  // next falling edge, core request lines get random levels
  task automatic tick();
    logic [31:0] r;
    @(negedge clk_sys);
    r = lcg_next();
    rom_oe   = r[16];
    rom_we   = r[17];
    rom_word = r[18];
    rom_d    = r[15:0];
    rom_addr = r[31:8];
  endtask

  task automatic send_word(input ioctl_addr_t addr, input word_t data);
    tick();
    ioctl_addr = addr;
    ioctl_dout = data;
    ioctl_wr   = 1'b1;
    tick();
    ioctl_wr   = 1'b0;
  endtask

  task automatic wait_release(input int limit);
    int n;
    n = 0;
    while (!core_reset_n && n < limit) begin
      tick();
      n++;
    end
    if (!core_reset_n) begin
      chk0.note_failure($sformatf("core reset was not released within %0d cycles", limit));
    end
  endtask

  // address in, one registered cycle, then compare
  task automatic read_check(input aram_addr_t a, input byte_t exp, input string what);
    tick();
    aram_addr = a;
    tick();
    chk0.expect_byte(a, exp, what);
  endtask

  task automatic core_write(input aram_addr_t a, input byte_t d);
    tick();
    aram_addr = a;
    aram_d    = d;
    aram_we   = 1'b1;
    tick();
    aram_we   = 1'b0;
  endtask

  initial begin
    int          errs_before;
    logic [31:0] r;
    aram_addr_t  a;
    logic [14:0] base;
    rows[0] = '{4'd9, 4'd3, 2'd0, 24'h07FFFF, 24'h001FFF, 4'd3, 6};
    rows[1] = '{4'd10, 4'd0, 2'd1, 24'h0FFFFF, 24'h000000, 4'd0, 4};
    rows[2] = '{4'd12, 4'd5, 2'd2, 24'h3FFFFF, 24'h007FFF, 4'd5, 8};
    rows[3] = '{4'd14, 4'd7, 2'd3, 24'hFFFFFF, 24'h01FFFF, 4'd7, 5};
    reset = 1'b0;
    core_reset = 1'b0;
    cart_download = 1'b0;
    spc_download = 1'b0;
    ioctl_wr = 1'b0;
    ioctl_addr = '0;
    ioctl_dout = '0;
    rom_size = '0;
    ram_size = '0;
    fill_mode = '0;
    rom_addr = '0;
    rom_d = '0;
    rom_oe = 1'b0;
    rom_we = 1'b0;
    rom_word = 1'b0;
    aram_addr = '0;
    aram_d = '0;
    aram_we = 1'b0;
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    chk0.check_reset_state();
    $display("reset state: %s", (chk0.error_total() == 0) ? "ok" : "failed");
    reset = 1'b1;
    for (int t = 0; t < NUM_ROWS; t++) begin
      errs_before = chk0.error_total();
      tick();
      rom_size = rows[t].rom_size;
      ram_size = rows[t].ram_size;
      fill_mode = rows[t].fill_mode;
      // short rom image, also starts the clear sweep
      cart_download = 1'b1;
      for (int i = 0; i < 4; i++) begin
        r = lcg_next();
        send_word(25'(2 * i), r[15:0]);
      end
      tick();
      cart_download = 1'b0;
      wait_release(CLEAR_TIMEOUT);
      chk0.check_masks(rows[t].rom_mask, rows[t].ram_mask, rows[t].sram_size, 1'b0);
      // last sweep write per word has address bit 0 set
      for (int i = 0; i < 8; i++) begin
        r = lcg_next();
        a = r[23:8];
        read_check(a, fill_pattern(rows[t].fill_mode, a | 16'd1), "clear");
      end
      // spc image, odd stride keeps word addresses distinct
      r = lcg_next();
      base = r[14:0];
      tick();
      spc_download = 1'b1;
      for (int i = 0; i < rows[t].spc_words; i++) begin
        r = lcg_next();
        spc_wa[i] = base + 15'(i * 37);
        spc_data[i] = r[15:0];
        send_word(25'(SPC_LOAD_OFFSET + {spc_wa[i], 1'b0}), spc_data[i]);
      end
      tick();
      spc_download = 1'b0;
      wait_release(SPC_TIMEOUT);
      chk0.check_masks(rows[t].rom_mask, rows[t].ram_mask, rows[t].sram_size, 1'b1);
      for (int i = 0; i < rows[t].spc_words; i++) begin
        read_check({spc_wa[i], 1'b0}, spc_data[i][7:0], "spc low");
        read_check({spc_wa[i], 1'b1}, spc_data[i][15:8], "spc high");
      end
      r = lcg_next();
      core_write(r[15:0], r[31:24]);
      read_check(r[15:0], r[31:24], "core write");
      if (chk0.error_total() == errs_before) begin
        $display("test %0d fill_mode %0d: ok", t, rows[t].fill_mode);
      end else begin
        failed_tests++;
        $display("test %0d fill_mode %0d: failed", t, rows[t].fill_mode);
      end
    end
    $display("tests %0d, failed %0d, errors %0d", NUM_ROWS, failed_tests, chk0.error_total());
    if (chk0.error_total() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* build.f */
design/snes_load_pkg.sv
design/load_sequencer.sv
design/ram_clear_seq.sv
design/sdram_port_ctrl.sv
design/aram_store.sv
design/snes_load_top.sv
sim/load_checker.sv
sim/tb_snes_load.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_snes_load
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
